// File: Makefile
# Verilator flow for the latch-memory FIFO

TOP = scmFifoTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f scmFifo.f --top-module $(TOP)

obj_dir/V$(TOP): scmFifo.f *.sv
	verilator --binary --timing -f scmFifo.f --top-module $(TOP)

# The log decides the outcome, a missing result line counts as a failure
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then \
	  echo "Simulation reported a failure"; \
	  exit 1; \
	elif ! grep -q "Result: PASSED" sim.log; then \
	  echo "Simulation ended without a result"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: clkGate.sv
// Glitch-free clock gate
`timescale 1ns/100ps

module clkGate (
  input  logic clk,
  input  logic en,
  output logic gatedClk
);

  // Enable as captured while the clock is low
  logic enLatched;

  // ----------------------------------------
  // Enable latch
  // ----------------------------------------

  // The latch is open only in the low phase of clk, so the enable is
  // frozen for the whole high phase and cannot cut a pulse short
  always_latch begin
    if (!clk) begin
      enLatched <= en;
    end
  end

  // ----------------------------------------
  // Gating
  // ----------------------------------------

  // A high phase passes through only when the enable was set before the edge
  assign gatedClk = clk & enLatched;

endmodule

// File: latchScm.sv
// Latch-based standard-cell memory
`timescale 1ns/100ps

module latchScm
  import scmFifoPkg::*;
(
  input  logic clk,
  // Read port
  input  logic readEnable,
  input  addrT readAddr,
  output dataT readData,
  // Write port
  input  logic writeEnable,
  input  addrT writeAddr,
  input  dataT writeData
);

  // Registered read address that selects the output word
  addrT readAddrReg;

  // Current value of every word, gathered for the read mux
  dataT memWords [numWords];

  // One bit per word, set for the word being written this cycle
  logic [numWords-1:0] writeOneHot;

  // Gated clock of every word
  logic [numWords-1:0] wordClk;

  // Write data held stable over the high phase in which the latch is open
  dataT writeDataReg;

  // Clock that pulses only in cycles with a write
  logic writeClk;

  // ----------------------------------------
  // Read side
  // ----------------------------------------

  // The address only moves when the reader asks for it
  always_ff @(posedge clk) begin
    if (readEnable) begin
      readAddrReg <= readAddr;
    end
  end

  // Output follows the selected latch without a further register stage
  assign readData = memWords[readAddrReg];

  // ----------------------------------------
  // Write decoder and global gate
  // ----------------------------------------

  // At most one bit is set, and none at all without writeEnable
  always_comb begin
    writeOneHot = '0;
    writeOneHot[writeAddr] = writeEnable;
  end

  // Idle cycles keep every word gate quiet at the root of the clock tree
  clkGate globalGate (
    .clk      (clk),
    .en       (writeEnable),
    .gatedClk (writeClk)
  );

  // ----------------------------------------
  // Write data sample
  // ----------------------------------------

  // Captured at the edge, so the latches see a value that is steady
  // while their clocks are high
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      writeDataReg <= writeData;
    end
  end

  // ----------------------------------------
  // Storage words
  // ----------------------------------------

  for (genvar w = 0; w < numWords; w++) begin : gWord
    // Latched contents of this word, undefined until first written
    dataT wordQ;

    // Each word has its own gate fed by its decoder bit
    clkGate wordGate (
      .clk      (writeClk),
      .en       (writeOneHot[w]),
      .gatedClk (wordClk[w])
    );

    // Transparent in the high phase after a write edge, holding afterwards
    always_latch begin
      if (wordClk[w]) begin
        wordQ <= writeDataReg;
      end
    end

    assign memWords[w] = wordQ;
  end

endmodule

// File: popSide.sv
// FIFO output side
`timescale 1ns/100ps

module popSide
  import scmFifoPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  // Consumer
  input  logic  pop,
  output logic  empty,
  output levelT level,
  // Pointer exchange with the input side
  input  ptrT   wrPtr,
  output ptrT   rdPtr,
  // Memory read port
  output logic  readEnable,
  output addrT  readAddr
);

  // High when the current pop really removes an entry
  logic popAccepted;

  // Read pointer as it will be after this cycle
  ptrT rdPtrNext;

  // ----------------------------------------
  // Status
  // ----------------------------------------

  // Equal pointers, wrap bit included, mean nothing is stored
  assign empty = (wrPtr == rdPtr);

  // The extra wrap bit makes the difference come out right across wraps,
  // giving numWords when full
  assign level = levelT'(wrPtr - rdPtr);

  // A pop from an empty buffer is dropped
  assign popAccepted = pop && !empty;

  // ----------------------------------------
  // Read pointer
  // ----------------------------------------

  // Step by one only on an accepted pop
  assign rdPtrNext = popAccepted ? rdPtr + ptrT'(1) : rdPtr;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdPtr <= '0;
    end else begin
      rdPtr <= rdPtrNext;
    end
  end

  // ----------------------------------------
  // Memory read controls
  // ----------------------------------------

  // The memory address register loads the new head at the same edge as
  // rdPtr, so the head word is on the output right after a pop
  assign readAddr = rdPtrNext[addrWidth-1:0];

  // Tracking the head every cycle also follows a push into an empty
  // buffer, since the head address is then the word just written
  // The enable stays low while reset is held
  assign readEnable = rstN;

endmodule

// File: pushSide.sv
// FIFO input side
`timescale 1ns/100ps

module pushSide
  import scmFifoPkg::*;
(
  input  logic clk,
  input  logic rstN,
  // Producer
  input  logic push,
  input  dataT pushData,
  output logic full,
  // Pointer exchange with the output side
  input  ptrT  rdPtr,
  output ptrT  wrPtr,
  // Memory write port
  output logic writeEnable,
  output addrT writeAddr,
  output dataT writeData
);

  // High when the current push will really be stored
  logic pushAccepted;

  // ----------------------------------------
  // Full flag
  // ----------------------------------------

  // Same word address but opposite wrap bits means the writer is a whole
  // lap ahead of the reader
  assign full = (wrPtr[ptrWidth-1] != rdPtr[ptrWidth-1]) &&
                (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);

  // A push into a full buffer is dropped
  // Nothing is accepted while reset is held
  assign pushAccepted = push && !full && rstN;

  // ----------------------------------------
  // Write pointer
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
    end else if (pushAccepted) begin
      wrPtr <= wrPtr + ptrT'(1);
    end
  end

  // ----------------------------------------
  // Memory write controls
  // ----------------------------------------

  // The memory samples the data at the same edge that moves the pointer
  assign writeEnable = pushAccepted;

  // Word address drops the wrap bit
  assign writeAddr = wrPtr[addrWidth-1:0];

  // Data needs no staging here, the memory has its own sample register
  assign writeData = pushData;

endmodule

// File: scmFifo.f
scmFifoPkg.sv
clkGate.sv
latchScm.sv
pushSide.sv
popSide.sv
scmFifo.sv
scmFifoTb.sv

// File: scmFifo.sv
// Latch-memory FIFO top level
`timescale 1ns/100ps

module scmFifo
  import scmFifoPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  // Producer
  input  logic  push,
  input  dataT  pushData,
  output logic  full,
  // Consumer, show-ahead
  input  logic  pop,
  output dataT  popData,
  output logic  empty,
  output levelT level
);

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------

  // Pointers crossing between the two sides
  ptrT wrPtr;
  ptrT rdPtr;

  // Memory write port, driven by the input side
  logic writeEnable;
  addrT writeAddr;
  dataT writeData;

  // Memory read port, driven by the output side
  logic readEnable;
  addrT readAddr;

  // Input side owns the write pointer and the full flag
  pushSide uPushSide (
    .clk         (clk),
    .rstN        (rstN),
    .push        (push),
    .pushData    (pushData),
    .full        (full),
    .rdPtr       (rdPtr),
    .wrPtr       (wrPtr),
    .writeEnable (writeEnable),
    .writeAddr   (writeAddr),
    .writeData   (writeData)
  );

  // Storage, whose read data is the head entry seen by the consumer
  latchScm uMem (
    .clk         (clk),
    .readEnable  (readEnable),
    .readAddr    (readAddr),
    .readData    (popData),
    .writeEnable (writeEnable),
    .writeAddr   (writeAddr),
    .writeData   (writeData)
  );

  // Output side owns the read pointer, empty flag and level
  popSide uPopSide (
    .clk        (clk),
    .rstN       (rstN),
    .pop        (pop),
    .empty      (empty),
    .level      (level),
    .wrPtr      (wrPtr),
    .rdPtr      (rdPtr),
    .readEnable (readEnable),
    .readAddr   (readAddr)
  );

endmodule

// File: scmFifoPkg.sv
// FIFO shared sizes and types
package scmFifoPkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Number of address bits into the latch memory
  localparam int addrWidth = 5;

  // Width of one payload word
  localparam int dataWidth = 32;

  // Memory depth, one word per address
  localparam int numWords = 2 ** addrWidth;

  // Pointers carry one extra wrap bit to tell full from empty
  localparam int ptrWidth = addrWidth + 1;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // Word address inside the memory
  typedef logic [addrWidth-1:0] addrT;

  // Read or write pointer, the top bit is the wrap bit
  typedef logic [ptrWidth-1:0] ptrT;

  // One payload word
  typedef logic [dataWidth-1:0] dataT;

  // Fill count from 0 up to numWords, which needs the wrap bit as well
  typedef logic [ptrWidth-1:0] levelT;

endpackage

// File: scmFifoTb.sv
// Directed FIFO testbench
`timescale 1ns/100ps

module scmFifoTb
  import scmFifoPkg::*;
();

  // ----------------------------------------
  // Test lengths and limits
  // ----------------------------------------

  localparam int resetCycles   = 10;
  localparam int resetTimeout  = 50;
  localparam int drainTimeout  = numWords + 8;
  localparam int overlapLevel  = 12;
  localparam int overlapCycles = 40;
  localparam int wrapCycles    = 600;

  logic  clk;
  logic  rstN;
  logic  push;
  dataT  pushData;
  logic  pop;
  dataT  popData;
  logic  full;
  logic  empty;
  levelT level;

  // Model of the buffer contents, head at index 0
  dataT model [$];

  integer seed;
  int     errorCount;
  int     testsRun;
  int     testsFailed;
  int     testStartErrors;
  int     waited;

  scmFifo dut (
    .clk      (clk),
    .rstN     (rstN),
    .push     (push),
    .pushData (pushData),
    .full     (full),
    .pop      (pop),
    .popData  (popData),
    .empty    (empty),
    .level    (level)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is released 10 ns after an edge, like every other input
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #10;
    rstN = 1'b1;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic checkData(input string name, input dataT expected, input dataT actual);
    if (actual !== expected) begin
      $display("ERR %0s: expected %h, got %h at %0t", name, expected, actual, $time);
      errorCount++;
    end
  endtask

  task automatic checkLevel(input string name, input levelT expected, input levelT actual);
    if (actual !== expected) begin
      $display("ERR %0s: expected %h, got %h at %0t", name, expected, actual, $time);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %0s: expected %h, got %h at %0t", name, expected, actual, $time);
      errorCount++;
    end
  endtask

  // Every output against the model, the head word only when something is stored
  task automatic compareOutputs();
    checkFlag("empty", model.size() == 0, empty);
    checkFlag("full", model.size() == numWords, full);
    checkLevel("level", levelT'(model.size()), level);
    if (model.size() > 0) begin
      checkData("popData", model[0], popData);
    end
  endtask

  // ----------------------------------------
  // Cycle helpers
  // ----------------------------------------

  // Returns 10 ns after the next rising edge, where inputs change and
  // the registered outputs have settled
  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  // One clock with the given strobes, then the model follows the rules
  task automatic applyCycle(input logic doPush, input dataT data, input logic doPop);
    logic pushOk;
    logic popOk;
    push     = doPush;
    pushData = data;
    pop      = doPop;
    // Acceptance is decided on the state before the edge
    pushOk = doPush && (model.size() < numWords);
    popOk  = doPop && (model.size() > 0);
    nextCycle();
    if (popOk) begin
      void'(model.pop_front());
    end
    if (pushOk) begin
      model.push_back(data);
    end
    push = 1'b0;
    pop  = 1'b0;
    compareOutputs();
  endtask

  task automatic reportTest(input string name);
    int found;
    found = errorCount - testStartErrors;
    testsRun++;
    if (found == 0) begin
      $display("test %0s: ok", name);
    end else begin
      testsFailed++;
      $display("test %0s: %0d errors", name, found);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic afterReset();
    testStartErrors = errorCount;
    checkFlag("empty", 1'b1, empty);
    checkFlag("full", 1'b0, full);
    checkLevel("level", '0, level);
    // An idle cycle must leave everything where it was
    applyCycle(1'b0, '0, 1'b0);
    reportTest("reset state");
  endtask

  task automatic singleEntry();
    dataT knownWord;
    testStartErrors = errorCount;
    knownWord = 32'ha5c3_0f96;
    applyCycle(1'b1, knownWord, 1'b0);
    checkFlag("empty", 1'b0, empty);
    checkLevel("level", levelT'(1), level);
    checkData("popData", knownWord, popData);
    applyCycle(1'b0, '0, 1'b1);
    checkFlag("empty", 1'b1, empty);
    reportTest("single entry");
  endtask

  task automatic fillAndOverflow();
    dataT word;
    dataT headBefore;
    testStartErrors = errorCount;
    for (int i = 0; i < numWords; i++) begin
      word = $random(seed);
      applyCycle(1'b1, word, 1'b0);
      // Full may only rise with the last word
      checkFlag("full", i == numWords - 1, full);
    end
    headBefore = model[0];
    // The extra word would land on the head address if it were not dropped
    applyCycle(1'b1, ~headBefore, 1'b0);
    checkLevel("level", levelT'(numWords), level);
    checkFlag("full", 1'b1, full);
    checkData("popData", headBefore, popData);
    reportTest("fill and overflow");
  endtask

  task automatic drainAndUnderflow();
    int popped;
    testStartErrors = errorCount;
    popped = 0;
    // Push order is checked through the model head on every pop
    while (empty !== 1'b1 && popped < drainTimeout) begin
      applyCycle(1'b0, '0, 1'b1);
      popped++;
    end
    if (empty !== 1'b1) begin
      $display("drain did not reach empty within %0d pops", drainTimeout);
      errorCount++;
    end else if (popped != numWords) begin
      $display("drain took %0d pops instead of %0d", popped, numWords);
      errorCount++;
    end
    applyCycle(1'b0, '0, 1'b1);
    checkFlag("empty", 1'b1, empty);
    checkFlag("full", 1'b0, full);
    checkLevel("level", '0, level);
    reportTest("drain and underflow");
  endtask

  task automatic pushWithPop();
    dataT word;
    testStartErrors = errorCount;
    for (int i = 0; i < overlapLevel; i++) begin
      word = $random(seed);
      applyCycle(1'b1, word, 1'b0);
    end
    for (int i = 0; i < overlapCycles; i++) begin
      word = $random(seed);
      applyCycle(1'b1, word, 1'b1);
      checkLevel("level", levelT'(overlapLevel), level);
    end
    for (int i = 0; i < overlapLevel; i++) begin
      applyCycle(1'b0, '0, 1'b1);
    end
    reportTest("simultaneous push and pop");
  endtask

  task automatic wrapAround();
    logic [31:0] r;
    logic        doPush;
    logic        doPop;
    dataT        word;
    testStartErrors = errorCount;
    for (int i = 0; i < wrapCycles; i++) begin
      r    = $random(seed);
      word = $random(seed);
      // Push-heavy, then pop-heavy, then balanced, so both flags get exercised
      if (i < wrapCycles / 3) begin
        doPush = (r[1:0] != 2'b00);
        doPop  = (r[3:2] == 2'b00);
      end else if (i < 2 * wrapCycles / 3) begin
        doPush = (r[1:0] == 2'b00);
        doPop  = (r[3:2] != 2'b00);
      end else begin
        doPush = r[0];
        doPop  = r[1];
      end
      applyCycle(doPush, word, doPop);
    end
    reportTest("wraparound");
  endtask

  task automatic closeRun();
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    push        = 1'b0;
    pushData    = '0;
    pop         = 1'b0;
    seed        = 32'hf94d_5bea;
    errorCount  = 0;
    testsRun    = 0;
    testsFailed = 0;
    waited      = 0;
    // rstN is stable at the edges, so it is sampled there
    while (rstN !== 1'b1 && waited < resetTimeout) begin
      @(posedge clk);
      waited++;
    end
    #10;
    if (rstN !== 1'b1) begin
      $display("reset was not released within %0d cycles", resetTimeout);
      errorCount++;
    end else begin
      afterReset();
      singleEntry();
      fillAndOverflow();
      drainAndUnderflow();
      pushWithPop();
      wrapAround();
    end
    closeRun();
  end

endmodule
